// ==== compile.f ====
src/cpuTypesPkg.sv
src/decodePkg.sv
src/decodeRb.sv
src/regFile.sv
src/regFileArbiter.sv
src/decodeStage.sv
src/decodeTop.sv
testbench/decodeTb.sv

// ==== run.sh ====
#!/bin/bash
# Build the decode testbench with Verilator, run it and grade the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module decodeTb -o decodeSim \
	&& ./obj_dir/decodeSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== src/cpuTypesPkg.sv ====
// ====================
// CPU base types
// Register numbers, operating modes, data words and register-file sizing
// shared by the decode stage, the arbiter and the register file
// ====================

package cpuTypesPkg;

	// Physical register file holds the 32 architectural registers plus
	// one banked stack pointer per operating mode
	localparam int NumRegs = 36;
	localparam int StackReg = 31;
	localparam int BankBase = 32;

	// Width of a register field inside an instruction
	localparam int ArchRegW = 5;

	typedef logic [ArchRegW-1:0] archReg_t;
	typedef logic [5:0] aregNo_t;
	typedef logic [31:0] word_t;

	typedef enum logic [1:0]
	{
		USER = 2'd0,
		SUPER = 2'd1,
		HYPER = 2'd2,
		MACHINE = 2'd3
	} operatingMode_t;

	// Maps an architectural register to its physical number
	// The stack pointer is banked by mode, everything else maps one to one
	function automatic aregNo_t mapStack(input archReg_t areg, input operatingMode_t om);
		if (areg == archReg_t'(StackReg))
			return aregNo_t'(BankBase + int'(om));
		return aregNo_t'(areg);
	endfunction

endpackage

// ==== src/decodePkg.sv ====
// ====================
// Instruction decode definitions
// Opcode encodings, the instruction word layout and the immediate rule
// ====================

package decodePkg;

	localparam int OpcodeW = 7;
	// Width of the short immediate carried in the low byte
	localparam int Imm8W = 8;

	// Only the opcodes that matter to operand decode are named here
	typedef enum logic [OpcodeW-1:0]
	{
		OP_NOP = 7'd0,
		OP_ADD = 7'd1,
		OP_SUB = 7'd2,
		OP_ADDI = 7'd3,
		OP_LOAD = 7'd4,
		OP_RTD = 7'd5,
		OP_FLT3 = 7'd6
	} opcode_t;

	// ====================
	// Instruction word
	// ====================

	// Bits 31:25 opcode, 24:20 Rt, 19:15 Ra, 14:10 Rb
	// Bit 9 selects the immediate in place of Rb, bit 8 negates Rb
	typedef struct packed
	{
		opcode_t opcode;
		cpuTypesPkg::archReg_t rt;
		cpuTypesPkg::archReg_t ra;
		cpuTypesPkg::archReg_t rb;
		logic immB;
		logic rbn;
		logic [Imm8W-1:0] imm8;
	} instr_t;

	// Opcodes that carry an immediate even when the immB flag is clear
	function automatic logic isImmOp(input opcode_t op);
		case (op)
		OP_ADDI,
		OP_LOAD:
			return 1'b1;
		default:
			return 1'b0;
		endcase
	endfunction

endpackage

// ==== src/decodeRb.sv ====
// ====================
// Rb operand decode
// Turns the Rb field into a physical register number with the
// zero and negate flags
// ====================

`timescale 1ns/100ps

module decodeRb
(
	input cpuTypesPkg::operatingMode_t om,
	input decodePkg::instr_t instr,
	output cpuTypesPkg::aregNo_t rb,
	output logic rbZero,
	output logic rbNeg
);
	import cpuTypesPkg::*;
	import decodePkg::*;

	archReg_t rbField;

	// Pick the architectural Rb before stack banking
	always_comb
	begin
		case (instr.opcode)
		// Return always reads the stack pointer
		OP_RTD:
			rbField = archReg_t'(StackReg);
		// Three-operand float ops use the field even with immB set
		OP_FLT3:
			rbField = instr.rb;
		default:
			if (instr.immB || isImmOp(instr.opcode))
				rbField = '0;
			else
				rbField = instr.rb;
		endcase
	end

	assign rb = mapStack(rbField, om);

	// Register zero reads as zero, so no fetch is needed for it
	assign rbZero = (rb == '0);
	assign rbNeg = instr.rbn;

endmodule

// ==== src/decodeStage.sv ====
// ====================
// Operand decode stage
// Accepts one instruction, decodes its register fields, reads Ra and Rb
// over APB and emits the result as a one-cycle pulse
// ====================

`timescale 1ns/100ps

module decodeStage
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input decodePkg::instr_t instr,
	input cpuTypesPkg::operatingMode_t om,
	output logic instrReady,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output cpuTypesPkg::aregNo_t paddr,
	output cpuTypesPkg::word_t pwdata,
	input cpuTypesPkg::word_t prdata,
	input logic pready,
	output logic outValid,
	output decodePkg::opcode_t opcode,
	output cpuTypesPkg::aregNo_t rt,
	output cpuTypesPkg::word_t opA,
	output cpuTypesPkg::word_t opB,
	output logic rbZero,
	output logic rbNeg
);
	import cpuTypesPkg::*;
	import decodePkg::*;

	typedef enum logic [1:0] {IDLE, READA, READB, DONE} decodeState_t;

	decodeState_t state;
	aregNo_t raDec;
	aregNo_t rtDec;
	aregNo_t rbDec;
	logic rbZeroDec;
	logic rbNegDec;
	logic accept;
	logic xferDone;

	// Values captured at acceptance and while reading
	opcode_t opQ;
	aregNo_t rtQ;
	aregNo_t rbQ;
	logic rbZeroQ;
	logic rbNegQ;
	logic useImmQ;
	logic [Imm8W-1:0] imm8Q;
	word_t aVal;
	word_t bVal;

	decodeRb uRb
	(
		.om(om),
		.instr(instr),
		.rb(rbDec),
		.rbZero(rbZeroDec),
		.rbNeg(rbNegDec)
	);

	// Ra and Rt follow the same stack bank rule as Rb
	assign raDec = mapStack(instr.ra, om);
	assign rtDec = mapStack(instr.rt, om);

	assign instrReady = (state == IDLE);
	assign accept = instrReady && instrValid;
	assign xferDone = psel && penable && pready;

	// This stage only ever reads the register file
	assign pwrite = 1'b0;
	assign pwdata = '0;

	// ====================
	// Control FSM
	// ====================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			psel <= 1'b0;
			penable <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= 1'b0;
			case (state)
			IDLE:
				if (accept)
				begin
					// Skip any read of register zero
					if (raDec != '0)
					begin
						psel <= 1'b1;
						state <= READA;
					end
					else if (!rbZeroDec)
					begin
						psel <= 1'b1;
						state <= READB;
					end
					else
						state <= DONE;
				end
			READA:
				if (!penable)
					penable <= 1'b1;
				else if (pready)
				begin
					// Rb setup phase follows straight on with psel kept high
					penable <= 1'b0;
					if (!rbZeroQ)
						state <= READB;
					else
					begin
						psel <= 1'b0;
						state <= DONE;
					end
				end
			READB:
				if (!penable)
					penable <= 1'b1;
				else if (pready)
				begin
					penable <= 1'b0;
					psel <= 1'b0;
					state <= DONE;
				end
			DONE:
			begin
				outValid <= 1'b1;
				state <= IDLE;
			end
			endcase
		end
	end

	// ====================
	// Operand datapath
	// ====================

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			opQ <= instr.opcode;
			rtQ <= rtDec;
			rbQ <= rbDec;
			rbZeroQ <= rbZeroDec;
			rbNegQ <= rbNegDec;
			imm8Q <= instr.imm8;
			// The immediate stands in for Rb only when Rb decoded to zero
			useImmQ <= rbZeroDec && (instr.immB || isImmOp(instr.opcode));
			aVal <= '0;
			bVal <= '0;
			paddr <= (raDec != '0) ? raDec : rbDec;
		end
		if (state == READA && xferDone)
		begin
			aVal <= prdata;
			paddr <= rbQ;
		end
		if (state == READB && xferDone)
			bVal <= prdata;
		// Results stay put until the next instruction finishes
		if (state == DONE)
		begin
			opcode <= opQ;
			rt <= rtQ;
			opA <= aVal;
			if (useImmQ)
				opB <= {{($bits(word_t) - Imm8W){1'b0}}, imm8Q};
			else if (rbNegQ)
				opB <= -bVal;
			else
				opB <= bVal;
			rbZero <= rbZeroQ;
			rbNeg <= rbNegQ;
		end
	end

	// Every access phase must come after a setup cycle of the same transfer
	assert property (@(posedge clk) disable iff (reset)
		$rose(penable) |-> psel && $past(psel));

endmodule

// ==== src/decodeTop.sv ====
// ====================
// Operand decode top level
// Decode stage and debug port share the register file through the arbiter
// ====================

`timescale 1ns/100ps

module decodeTop
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input decodePkg::instr_t instr,
	input cpuTypesPkg::operatingMode_t om,
	output logic instrReady,
	output logic outValid,
	output decodePkg::opcode_t opcode,
	output cpuTypesPkg::aregNo_t rt,
	output cpuTypesPkg::word_t opA,
	output cpuTypesPkg::word_t opB,
	output logic rbZero,
	output logic rbNeg,
	input logic dbgPsel,
	input logic dbgPenable,
	input logic dbgPwrite,
	input cpuTypesPkg::aregNo_t dbgPaddr,
	input cpuTypesPkg::word_t dbgPwdata,
	output cpuTypesPkg::word_t dbgPrdata,
	output logic dbgPready
);
	import cpuTypesPkg::*;

	// Decode stage to arbiter
	logic decPsel;
	logic decPenable;
	logic decPwrite;
	aregNo_t decPaddr;
	word_t decPwdata;
	word_t decPrdata;
	logic decPready;

	// Arbiter to register file
	logic rfPsel;
	logic rfPenable;
	logic rfPwrite;
	aregNo_t rfPaddr;
	word_t rfPwdata;
	word_t rfPrdata;
	logic rfPready;

	decodeStage uStage
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.om(om),
		.instrReady(instrReady),
		.psel(decPsel),
		.penable(decPenable),
		.pwrite(decPwrite),
		.paddr(decPaddr),
		.pwdata(decPwdata),
		.prdata(decPrdata),
		.pready(decPready),
		.outValid(outValid),
		.opcode(opcode),
		.rt(rt),
		.opA(opA),
		.opB(opB),
		.rbZero(rbZero),
		.rbNeg(rbNeg)
	);

	regFileArbiter uArb
	(
		.clk(clk),
		.reset(reset),
		.decPsel(decPsel),
		.decPenable(decPenable),
		.decPwrite(decPwrite),
		.decPaddr(decPaddr),
		.decPwdata(decPwdata),
		.decPrdata(decPrdata),
		.decPready(decPready),
		.dbgPsel(dbgPsel),
		.dbgPenable(dbgPenable),
		.dbgPwrite(dbgPwrite),
		.dbgPaddr(dbgPaddr),
		.dbgPwdata(dbgPwdata),
		.dbgPrdata(dbgPrdata),
		.dbgPready(dbgPready),
		.psel(rfPsel),
		.penable(rfPenable),
		.pwrite(rfPwrite),
		.paddr(rfPaddr),
		.pwdata(rfPwdata),
		.prdata(rfPrdata),
		.pready(rfPready)
	);

	regFile uRegs
	(
		.clk(clk),
		.reset(reset),
		.psel(rfPsel),
		.penable(rfPenable),
		.pwrite(rfPwrite),
		.paddr(rfPaddr),
		.pwdata(rfPwdata),
		.prdata(rfPrdata),
		.pready(rfPready)
	);

endmodule

// ==== src/regFile.sv ====
// ====================
// Register file
// APB slave with 36 data words and zero wait states
// ====================

`timescale 1ns/100ps

module regFile
(
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input cpuTypesPkg::aregNo_t paddr,
	input cpuTypesPkg::word_t pwdata,
	output cpuTypesPkg::word_t prdata,
	output logic pready
);
	import cpuTypesPkg::*;

	word_t mem [NumRegs];

	// Every access phase completes at once
	assign pready = psel && penable;

	// Out-of-range addresses read as zero
	assign prdata = (paddr < NumRegs) ? mem[paddr] : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NumRegs; i++)
				mem[i] <= '0;
		end
		// Writes land in the access phase
		else if (psel && penable && pwrite && paddr < NumRegs)
			mem[paddr] <= pwdata;
	end

	// Masters only ever address the 36 physical registers
	assert property (@(posedge clk) disable iff (reset) psel |-> paddr < NumRegs);

endmodule

// ==== src/regFileArbiter.sv ====
// ====================
// Register file arbiter
// Round-robin choice between the decode and debug APB masters,
// one transfer at a time towards the register file
// ====================

`timescale 1ns/100ps

module regFileArbiter
(
	input logic clk,
	input logic reset,
	input logic decPsel,
	input logic decPenable,
	input logic decPwrite,
	input cpuTypesPkg::aregNo_t decPaddr,
	input cpuTypesPkg::word_t decPwdata,
	output cpuTypesPkg::word_t decPrdata,
	output logic decPready,
	input logic dbgPsel,
	input logic dbgPenable,
	input logic dbgPwrite,
	input cpuTypesPkg::aregNo_t dbgPaddr,
	input cpuTypesPkg::word_t dbgPwdata,
	output cpuTypesPkg::word_t dbgPrdata,
	output logic dbgPready,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output cpuTypesPkg::aregNo_t paddr,
	output cpuTypesPkg::word_t pwdata,
	input cpuTypesPkg::word_t prdata,
	input logic pready
);
	// busy marks the access phase of the transfer in flight
	logic busy;
	logic grantQ;
	logic lastDbg;
	logic pickDbg;
	logic grant;
	logic start;

	// On a tie take whichever master was not served last
	assign pickDbg = dbgPsel && (!decPsel || !lastDbg);
	assign start = !busy && (decPsel || dbgPsel);
	assign grant = busy ? grantQ : pickDbg;

	// The slave gets its own setup phase on the grant cycle, so a master
	// that waited in its access phase still gives a legal transfer
	assign psel = start || busy;
	assign penable = busy;
	assign pwrite = grant ? dbgPwrite : decPwrite;
	assign paddr = grant ? dbgPaddr : decPaddr;
	assign pwdata = grant ? dbgPwdata : decPwdata;

	assign decPrdata = prdata;
	assign dbgPrdata = prdata;
	assign decPready = busy && !grantQ && decPenable && pready;
	assign dbgPready = busy && grantQ && dbgPenable && pready;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			grantQ <= 1'b0;
			lastDbg <= 1'b1;
		end
		else if (busy)
		begin
			if (pready)
				busy <= 1'b0;
		end
		else if (start)
		begin
			busy <= 1'b1;
			grantQ <= pickDbg;
			lastDbg <= pickDbg;
		end
	end

	// The transfer set up on the slave keeps its address and direction
	// until its access completes
	assert property (@(posedge clk) disable iff (reset)
		busy |-> $stable(paddr) && $stable(pwrite));

endmodule

// ==== testbench/decodeTb.sv ====
// ====================
// Operand decode testbench
// Preloads the register file over the debug port, runs a table of
// instructions through the decode stage and checks every result
// ====================

`timescale 1ns/100ps

module decodeTb;
	import cpuTypesPkg::*;
	import decodePkg::*;

	localparam int TimeoutCycles = 50;
	localparam int Seed = 37827;

	logic clk;
	logic reset;
	logic instrValid;
	instr_t instr;
	operatingMode_t om;
	logic instrReady;
	logic outValid;
	opcode_t opcode;
	aregNo_t rt;
	word_t opA;
	word_t opB;
	logic rbZero;
	logic rbNeg;
	logic dbgPsel;
	logic dbgPenable;
	logic dbgPwrite;
	aregNo_t dbgPaddr;
	word_t dbgPwdata;
	word_t dbgPrdata;
	logic dbgPready;

	// Copy of what the register file should hold after the preload
	word_t model [NumRegs];
	// Stimulus table, one entry per decode test
	instr_t testInstr [$];
	operatingMode_t testMode [$];
	string testName [$];
	int passCount;
	int failCount;
	// Set once any wait runs out, which stops all further stimulus
	bit hung;

	decodeTop UUT
	(
		.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr), .om(om),
		.instrReady(instrReady), .outValid(outValid), .opcode(opcode), .rt(rt),
		.opA(opA), .opB(opB), .rbZero(rbZero), .rbNeg(rbNeg),
		.dbgPsel(dbgPsel), .dbgPenable(dbgPenable), .dbgPwrite(dbgPwrite),
		.dbgPaddr(dbgPaddr), .dbgPwdata(dbgPwdata), .dbgPrdata(dbgPrdata),
		.dbgPready(dbgPready)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// Reference decode
	// ====================

	// Register 31 is the stack pointer, banked above the 32 normal registers
	function automatic aregNo_t physReg(input logic [4:0] areg, input operatingMode_t mode);
		if (areg == 5'd31)
			return aregNo_t'(BankBase + int'(mode));
		return {1'b0, areg};
	endfunction

	task automatic predict(input instr_t ins, input operatingMode_t mode,
		output word_t expA, output word_t expB, output aregNo_t expRt,
		output logic expZero, output logic expNeg);
		logic [4:0] rbArch;
		aregNo_t raPhys;
		aregNo_t rbPhys;
		logic immApplies;
		word_t bReg;
		immApplies = ins.immB || ins.opcode == OP_ADDI || ins.opcode == OP_LOAD;
		// RTD pops through the stack pointer and FLT3 always has three registers
		if (ins.opcode == OP_RTD)
			rbArch = 5'd31;
		else if (ins.opcode == OP_FLT3)
			rbArch = ins.rb;
		else if (immApplies)
			rbArch = 5'd0;
		else
			rbArch = ins.rb;
		raPhys = physReg(ins.ra, mode);
		rbPhys = physReg(rbArch, mode);
		expRt = physReg(ins.rt, mode);
		expZero = (rbPhys == '0);
		expNeg = ins.rbn;
		expA = (raPhys == '0) ? '0 : model[raPhys];
		bReg = (rbPhys == '0) ? '0 : model[rbPhys];
		if (expZero && immApplies)
			expB = {24'd0, ins.imm8};
		else if (ins.rbn)
			expB = -bReg;
		else
			expB = bReg;
	endtask

	// ====================
	// Stimulus helpers
	// ====================

	task automatic addRow(input string name, input opcode_t op, input int rtNo, input int raNo,
		input int rbNo, input bit immB, input bit rbn, input int imm8, input operatingMode_t mode);
		instr_t ins;
		ins.opcode = op;
		ins.rt = archReg_t'(rtNo);
		ins.ra = archReg_t'(raNo);
		ins.rb = archReg_t'(rbNo);
		ins.immB = immB;
		ins.rbn = rbn;
		ins.imm8 = 8'(imm8);
		testInstr.push_back(ins);
		testMode.push_back(mode);
		testName.push_back(name);
	endtask

	// One APB transfer on the debug port, setup then access until pready
	task automatic debugTransfer(input logic write, input aregNo_t addr, input word_t wdata,
		output word_t rdata);
		int cycles;
		rdata = '0;
		if (!hung)
		begin
			@(posedge clk);
			dbgPsel <= 1'b1;
			dbgPenable <= 1'b0;
			dbgPwrite <= write;
			dbgPaddr <= addr;
			dbgPwdata <= wdata;
			@(posedge clk);
			dbgPenable <= 1'b1;
			cycles = 0;
			@(negedge clk);
			// The arbiter holds pready low while the decode stage owns the bus
			while (!dbgPready && cycles < TimeoutCycles)
			begin
				@(negedge clk);
				cycles++;
			end
			if (!dbgPready)
			begin
				$display("Timeout: debug port got no pready for register %0d", addr);
				hung = 1'b1;
			end
			else
			begin
				rdata = dbgPrdata;
				@(posedge clk);
				dbgPsel <= 1'b0;
				dbgPenable <= 1'b0;
			end
		end
	endtask

	// Sends one table row into the decode stage and checks the result
	task automatic runDecode(input int idx, output bit ok);
		instr_t ins;
		operatingMode_t mode;
		word_t expA;
		word_t expB;
		aregNo_t expRt;
		logic expZero;
		logic expNeg;
		int cycles;
		ins = testInstr[idx];
		mode = testMode[idx];
		ok = 1'b0;
		predict(ins, mode, expA, expB, expRt, expZero, expNeg);
		cycles = 0;
		@(negedge clk);
		while (!instrReady && cycles < TimeoutCycles)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!instrReady)
		begin
			$display("Timeout: instrReady stayed low before test %0d", idx);
			hung = 1'b1;
		end
		else
		begin
			@(posedge clk);
			instrValid <= 1'b1;
			instr <= ins;
			om <= mode;
			@(posedge clk);
			instrValid <= 1'b0;
			cycles = 0;
			@(negedge clk);
			while (!outValid && cycles < TimeoutCycles)
			begin
				@(negedge clk);
				cycles++;
			end
			if (!outValid)
			begin
				$display("Timeout: no outValid pulse for test %0d", idx);
				hung = 1'b1;
			end
			else
			begin
				ok = 1'b1;
				if (opcode !== ins.opcode)
				begin
					$display("Mismatch opcode exp %h got %h", ins.opcode, opcode);
					ok = 1'b0;
				end
				if (rt !== expRt)
				begin
					$display("Mismatch rt exp %h got %h", expRt, rt);
					ok = 1'b0;
				end
				if (opA !== expA)
				begin
					$display("Mismatch opA exp %h got %h", expA, opA);
					ok = 1'b0;
				end
				if (opB !== expB)
				begin
					$display("Mismatch opB exp %h got %h", expB, opB);
					ok = 1'b0;
				end
				if (rbZero !== expZero)
				begin
					$display("Mismatch rbZero exp %h got %h", expZero, rbZero);
					ok = 1'b0;
				end
				if (rbNeg !== expNeg)
				begin
					$display("Mismatch rbNeg exp %h got %h", expNeg, rbNeg);
					ok = 1'b0;
				end
			end
		end
	endtask

	task automatic logResult(input string name, input bit ok);
		if (ok)
		begin
			passCount++;
			$display("test %s passed", name);
		end
		else
		begin
			failCount++;
			$display("test %s failed", name);
		end
	endtask

	// ====================
	// Test sequence
	// ====================

	initial
	begin
		bit ok;
		word_t rd;
		aregNo_t addr;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		om = USER;
		dbgPsel = 1'b0;
		dbgPenable = 1'b0;
		dbgPwrite = 1'b0;
		dbgPaddr = '0;
		dbgPwdata = '0;
		passCount = 0;
		failCount = 0;
		hung = 1'b0;
		void'($urandom(Seed));

		addRow("add registers", OP_ADD, 3, 5, 7, 0, 0, 0, USER);
		addRow("sub registers", OP_SUB, 10, 1, 2, 0, 0, 0, SUPER);
		addRow("stack user", OP_ADD, 31, 31, 31, 0, 0, 0, USER);
		addRow("stack super", OP_ADD, 31, 31, 31, 0, 0, 0, SUPER);
		addRow("stack hyper", OP_ADD, 31, 31, 31, 0, 0, 0, HYPER);
		addRow("stack machine", OP_ADD, 31, 31, 31, 0, 0, 0, MACHINE);
		addRow("stack rb only", OP_SUB, 6, 9, 31, 0, 0, 0, HYPER);
		addRow("addi immediate", OP_ADDI, 4, 6, 9, 0, 0, 'h5a, USER);
		addRow("load immediate", OP_LOAD, 2, 31, 12, 0, 0, 'hc3, HYPER);
		addRow("immB on sub", OP_SUB, 7, 8, 8, 1, 0, 'h7f, MACHINE);
		addRow("flt3 reads rb", OP_FLT3, 1, 2, 8, 1, 0, 'h11, SUPER);
		addRow("negate rb", OP_ADD, 13, 0, 13, 0, 1, 0, USER);
		addRow("negate stack", OP_SUB, 5, 31, 31, 0, 1, 0, HYPER);
		addRow("rtd machine", OP_RTD, 0, 0, 20, 0, 0, 0, MACHINE);
		addRow("rtd user", OP_RTD, 30, 4, 0, 0, 0, 0, USER);
		addRow("zero operands", OP_ADD, 9, 0, 0, 0, 1, 0, SUPER);
		addRow("addi negate", OP_ADDI, 11, 17, 3, 0, 1, 'hf0, USER);

		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Idle outputs right after reset
		@(negedge clk);
		ok = 1'b1;
		if (instrReady !== 1'b1)
		begin
			$display("Mismatch instrReady exp %h got %h", 1'b1, instrReady);
			ok = 1'b0;
		end
		if (outValid !== 1'b0)
		begin
			$display("Mismatch outValid exp %h got %h", 1'b0, outValid);
			ok = 1'b0;
		end
		if (dbgPready !== 1'b0)
		begin
			$display("Mismatch dbgPready exp %h got %h", 1'b0, dbgPready);
			ok = 1'b0;
		end
		logResult("after reset", ok);

		// Register zero is never written and always reads as zero
		model[0] = '0;
		for (int r = 1; r < NumRegs && !hung; r++)
		begin
			model[r] = $urandom;
			debugTransfer(1'b1, aregNo_t'(r), model[r], rd);
		end

		for (int i = 0; i < testInstr.size() && !hung; i++)
		begin
			runDecode(i, ok);
			if (!hung)
				logResult(testName[i], ok);
		end

		// Same rows again with a debug read racing each decode
		for (int i = 0; i < testInstr.size() && !hung; i++)
		begin
			addr = aregNo_t'($urandom_range(NumRegs - 1, 1));
			fork
				runDecode(i, ok);
				begin
					repeat (i % 4) @(posedge clk);
					debugTransfer(1'b0, addr, '0, rd);
				end
			join
			if (!hung && rd !== model[addr])
			begin
				$display("Mismatch dbgPrdata exp %h got %h", model[addr], rd);
				ok = 1'b0;
			end
			if (!hung)
				logResult({"shared ", testName[i]}, ok);
		end

		$display("Summary: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0 && !hung)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
